// ==== design/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  imem_in,
  output mem_out_type imem_out,
  input  mem_in_type  dmem_in,
  output mem_out_type dmem_out,
  output mem_in_type  bus_req,
  input  mem_out_type bus_rsp
);

  access_type owner;
  access_type owner_next;
  mem_in_type held_req;
  mem_in_type held_req_next;

  // grant and bus drive
  always_comb begin
    owner_next    = owner;
    held_req_next = held_req;
    bus_req       = held_req;
    if (owner == no_access) begin
      bus_req = '0;
      // data port has priority
      if (dmem_in.mem_valid) begin
        owner_next    = data_access;
        held_req_next = dmem_in;
        bus_req       = dmem_in;
      end else if (imem_in.mem_valid) begin
        owner_next    = instr_access;
        held_req_next = imem_in;
        bus_req       = imem_in;
      end
    end else if (bus_rsp.mem_ready) begin
      // next grant waits one cycle after ready
      owner_next = no_access;
    end
  end

  // response goes to the owner only
  always_comb begin
    imem_out = '0;
    dmem_out = '0;
    case (owner)
      instr_access: begin
        imem_out = bus_rsp;
      end
      data_access: begin
        dmem_out = bus_rsp;
      end
      default: begin
        imem_out = '0;
        dmem_out = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      owner <= no_access;
    end else begin
      owner <= owner_next;
    end
  end

  always_ff @(posedge clk) begin
    held_req <= held_req_next;
  end

  // one port answered at a time
  a_ready_onehot: assert property (
    @(posedge clk) disable iff (!rst)
    !(imem_out.mem_ready && dmem_out.mem_ready)
  );

  // no direct handover between ports
  a_owner_via_idle: assert property (
    @(posedge clk) disable iff (!rst)
    (owner != no_access) |=> (owner == $past(owner)) || (owner == no_access)
  );

  // a bus ready always has a port to go to
  a_ready_has_owner: assert property (
    @(posedge clk) disable iff (!rst)
    bus_rsp.mem_ready |-> (owner != no_access)
  );

endmodule

// ==== design/mem_ctrl.sv ====
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_ctrl
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  bus_req,
  output mem_out_type bus_rsp
);

  mem_state_type              state;
  mem_state_type              state_next;
  logic                       accept;
  logic                       is_write;
  logic                       array_we;
  logic                       timer_done;
  logic [`MEM_INDEX_BITS-1:0] bus_index;
  logic [`MEM_INDEX_BITS-1:0] acc_index;
  logic [`MEM_INDEX_BITS-1:0] array_index;
  logic [31:0]                array_rdata;

  // upper address bits wrap
  assign bus_index = bus_req.mem_addr[`MEM_INDEX_BITS+1:2];

  assign accept   = (state == mem_idle) && bus_req.mem_valid;
  assign array_we = accept && (bus_req.mem_wstrb != 4'b0000);

  // keep the accepted word addressed so rdata stays stable
  assign array_index = (state == mem_idle) ? bus_index : acc_index;

  always_comb begin
    state_next = state;
    case (state)
      mem_idle: begin
        if (accept) begin
          state_next = mem_wait;
        end
      end
      mem_wait: begin
        if (timer_done) begin
          state_next = mem_respond;
        end
      end
      default: begin
        state_next = mem_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= mem_idle;
      is_write <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        is_write <= (bus_req.mem_wstrb != 4'b0000);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_index <= bus_index;
    end
  end

  // writes answer with zero data
  always_comb begin
    bus_rsp.mem_ready = (state == mem_respond);
    bus_rsp.mem_rdata = '0;
    if ((state == mem_respond) && !is_write) begin
      bus_rsp.mem_rdata = array_rdata;
    end
  end

  wait_timer i_timer (
    .clk   (clk),
    .rst   (rst),
    .load  (accept),
    .count (`MEM_INDEX_BITS'(`MEM_WAIT_CYCLES)),
    .done  (timer_done)
  );

  sram_array i_array (
    .clk   (clk),
    .we    (array_we),
    .index (array_index),
    .wdata (bus_req.mem_wdata),
    .wstrb (bus_req.mem_wstrb),
    .rdata (array_rdata)
  );

  a_ready_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    bus_rsp.mem_ready |=> !bus_rsp.mem_ready
  );

  // requester side must hold the access until ready
  a_valid_held: assert property (
    @(posedge clk) disable iff (!rst)
    (state != mem_idle) |-> bus_req.mem_valid
  );

endmodule

// ==== design/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// array size in 32-bit words
`define MEM_DEPTH_WORDS 256

// word index taken from address bits 9:2
`define MEM_INDEX_BITS 8

// wait states before ready, at least 1
`define MEM_WAIT_CYCLES 2

`endif

// ==== design/mem_pkg.sv ====
package mem_pkg;

  // request from a port, nonzero strobe means write
  typedef struct packed {
    logic        mem_valid;
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
  } mem_in_type;

  // response, ready is a one-cycle pulse
  typedef struct packed {
    logic        mem_ready;
    logic [31:0] mem_rdata;
  } mem_out_type;

  // which port owns the memory bus
  typedef enum logic [1:0] {
    no_access    = 2'b00,
    instr_access = 2'b01,
    data_access  = 2'b10
  } access_type;

  // memory controller states
  typedef enum logic [1:0] {
    mem_idle    = 2'b00,
    mem_wait    = 2'b01,
    mem_respond = 2'b10
  } mem_state_type;

endpackage

// ==== design/mem_subsystem.sv ====
`timescale 1ns/100ps

module mem_subsystem
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  imem_in,
  output mem_out_type imem_out,
  input  mem_in_type  dmem_in,
  output mem_out_type dmem_out
);

  // shared memory bus between arbiter and controller
  mem_in_type  bus_req;
  mem_out_type bus_rsp;

  mem_arbiter i_arbiter (
    .clk      (clk),
    .rst      (rst),
    .imem_in  (imem_in),
    .imem_out (imem_out),
    .dmem_in  (dmem_in),
    .dmem_out (dmem_out),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp)
  );

  mem_ctrl i_ctrl (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

endmodule

// ==== design/sram_array.sv ====
`timescale 1ns/100ps
`include "mem_defines.svh"

module sram_array (
  input  logic                       clk,
  input  logic                       we,
  input  logic [`MEM_INDEX_BITS-1:0] index,
  input  logic [31:0]                wdata,
  input  logic [3:0]                 wstrb,
  output logic [31:0]                rdata
);

  logic [31:0] mem [`MEM_DEPTH_WORDS];

  // byte lanes follow the strobe bits
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // registered read, held while index is stable
  always_ff @(posedge clk) begin
    if (!we) begin
      rdata <= mem[index];
    end
  end

endmodule

// ==== design/wait_timer.sv ====
`timescale 1ns/100ps
`include "mem_defines.svh"

module wait_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load,
  input  logic [`MEM_INDEX_BITS-1:0] count,
  output logic                       done
);

  logic [`MEM_INDEX_BITS-1:0] cnt;

  // the load edge already starts the first wait state
  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt <= '0;
    end else if (load) begin
      cnt <= count - 1'b1;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign done = (cnt == '0) && !load;

  // zero wait states would underflow the counter
  a_count_nonzero: assert property (
    @(posedge clk) disable iff (!rst)
    load |-> (count != '0)
  );

endmodule

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/100ps
`include "mem_defines.svh"

module tb_mem_subsystem
  import mem_pkg::*;
;

  // about twice the summed length of all tests
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int FREE_LATENCY   = `MEM_WAIT_CYCLES + 1;

  logic        clk = 1'b0;
  logic        rst;
  mem_in_type  imem_in;
  mem_in_type  dmem_in;
  mem_out_type imem_out;
  mem_out_type dmem_out;

  int          seed = 16138;
  string       test_name = "reset";
  int          cycle_count = 0;
  int          issued = 0;
  int          answered = 0;
  mem_in_type  dq[$];
  mem_in_type  iq[$];
  logic [31:0] shadow [`MEM_DEPTH_WORDS];
  logic [31:0] r;
  logic [31:0] addr_a;
  logic [31:0] addr_b;
  logic [31:0] i_addr;
  int          lat_d;
  int          lat_i;
  int          d_gap;
  int          i_gap;
  logic [3:0]  d_strb;

  mem_subsystem i_dut (
    .clk      (clk),
    .rst      (rst),
    .imem_in  (imem_in),
    .imem_out (imem_out),
    .dmem_in  (dmem_in),
    .dmem_out (dmem_out)
  );

  always #20 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error: test %s, %s expected %h actual %h",
                                  test_name, what, expected, actual));
    end
  endtask

  // strobed bytes replace the old word's bytes
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  wstrb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // accesses complete in ready order, so the shadow follows it
  task automatic settle_response(input bit on_data, input logic [31:0] rdata);
    mem_in_type  req;
    int          idx;
    logic [31:0] expected;
    if ((on_data && dq.size() == 0) || (!on_data && iq.size() == 0)) begin
      stop_with_failure($sformatf("test %s: ready on the %s port with no open request",
                                  test_name, on_data ? "data" : "instruction"));
    end else begin
      req = on_data ? dq.pop_front() : iq.pop_front();
      idx = req.mem_addr[9:2];
      expected = 32'd0;
      if (req.mem_wstrb != 4'b0000) begin
        shadow[idx] = merge_word(shadow[idx], req.mem_wdata, req.mem_wstrb);
      end else begin
        expected = shadow[idx];
      end
      check_value(on_data ? "dmem rdata" : "imem rdata", expected, rdata);
      answered++;
    end
  endtask

  // comparison process
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("timeout: the tests did not finish within the cycle limit");
    end else if (rst) begin
      check_value("ready overlap", 32'd0, {31'd0, imem_out.mem_ready & dmem_out.mem_ready});
      // the port that is not answered sees zeros
      if (dmem_out.mem_ready) begin
        check_value("imem rdata during dmem ready", 32'd0, imem_out.mem_rdata);
        settle_response(1'b1, dmem_out.mem_rdata);
      end
      if (imem_out.mem_ready) begin
        check_value("dmem rdata during imem ready", 32'd0, dmem_out.mem_rdata);
        settle_response(1'b0, imem_out.mem_rdata);
      end
    end
  end

  // drives one request and holds it until its ready, called at edge + 2 ns
  task automatic run_access(input bit on_data, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input int gap, output int latency);
    mem_in_type req;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    req = '{mem_valid: 1'b1, mem_instr: !on_data, mem_addr: addr,
            mem_wdata: wdata, mem_wstrb: wstrb};
    issued++;
    if (on_data) begin
      dq.push_back(req);
      dmem_in = req;
    end else begin
      iq.push_back(req);
      imem_in = req;
    end
    latency = 0;
    @(posedge clk);
    while (!(on_data ? dmem_out.mem_ready : imem_out.mem_ready)) begin
      @(posedge clk);
      latency++;
    end
    #2;
    if (on_data) begin
      dmem_in = '0;
    end else begin
      imem_in = '0;
    end
  endtask

  initial begin
    rst     = 1'b0;
    imem_in = '0;
    dmem_in = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b1;

    test_name = "reset_idle";
    repeat (8) begin
      @(posedge clk);
      check_value("idle readies", 32'd0, {30'd0, imem_out.mem_ready, dmem_out.mem_ready});
    end
    #2;

    test_name = "write_read";
    addr_a = $random(seed);
    run_access(1'b1, addr_a, $random(seed), 4'hf, 0, lat_d);
    check_value("write latency", FREE_LATENCY, lat_d);
    run_access(1'b1, addr_a, 32'd0, 4'h0, 0, lat_d);
    check_value("read latency", FREE_LATENCY, lat_d);

    // reads use an alias with other upper bits
    test_name = "partial_write";
    repeat (24) begin
      addr_a = $random(seed);
      r      = $random(seed);
      addr_b = {r[31:10], addr_a[9:2], r[1:0]};
      run_access(1'b1, addr_a, $random(seed), 4'hf, 0, lat_d);
      repeat (2) begin
        r = $random(seed);
        run_access(1'b1, addr_a, $random(seed), r[3:0], 0, lat_d);
      end
      run_access(1'b1, addr_b, 32'd0, 4'h0, 0, lat_d);
    end

    test_name = "contention";
    addr_a = 32'h0000_0040;
    addr_b = 32'h0000_0080;
    run_access(1'b1, addr_a, 32'h1111_aaaa, 4'hf, 0, lat_d);
    run_access(1'b1, addr_b, 32'h2222_bbbb, 4'hf, 0, lat_d);
    fork
      run_access(1'b1, addr_a, 32'd0, 4'h0, 0, lat_d);
      run_access(1'b0, addr_b, 32'd0, 4'h0, 0, lat_i);
    join
    check_value("data latency", FREE_LATENCY, lat_d);
    // one idle cycle after the data ready, then a full access
    check_value("instr latency", 2 * FREE_LATENCY + 1, lat_i);

    // sixteen words, so both ports collide on addresses
    test_name = "random_mix";
    for (int w = 0; w < 16; w++) begin
      run_access(1'b1, w << 2, $random(seed), 4'hf, 0, lat_d);
    end
    repeat (120) begin
      r      = $random(seed);
      addr_a = {r[31:10], 4'b0000, r[3:0], r[5:4]};
      d_gap  = r[7:6] % 3;
      i_gap  = r[9:8] % 3;
      d_strb = r[13:12] == 2'b00 ? r[19:16] : 4'h0;
      r      = $random(seed);
      i_addr = {r[31:10], 4'b0000, r[3:0], r[5:4]};
      addr_b = $random(seed);
      fork
        run_access(1'b1, addr_a, addr_b, d_strb, d_gap, lat_d);
        run_access(1'b0, i_addr, 32'd0, 4'h0, i_gap, lat_i);
      join
    end

    test_name = "drain";
    repeat (8) @(posedge clk);
    if (dq.size() == 0 && iq.size() == 0 && issued == answered) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure("requests were left without a ready at the end of the run");
    end
  end

endmodule

// ==== list.f ====
+incdir+design
design/mem_pkg.sv
design/mem_arbiter.sv
design/wait_timer.sv
design/sram_array.sv
design/mem_ctrl.sv
design/mem_subsystem.sv
dv/tb_mem_subsystem.sv
